/* design/execPkg.sv */
package execPkg;

    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [3:0]            regIdx_t;
    typedef logic [15:0]           imm_t;
    typedef logic [15:0]           target_t;
    typedef logic [3:0]            flags_t;   // NZCV

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Instruction class, bits 31..30
    localparam logic [1:0] CLASS_IMM    = 2'b00;
    localparam logic [1:0] CLASS_REG    = 2'b01;
    localparam logic [1:0] CLASS_MEM    = 2'b10;
    localparam logic [1:0] CLASS_BRANCH = 2'b11;

    // ALU function codes, bit 3 selects flag update
    localparam logic [3:0] FN_ADD  = 4'b0001;
    localparam logic [3:0] FN_SUB  = 4'b0010;
    localparam logic [3:0] FN_AND  = 4'b0011;
    localparam logic [3:0] FN_OR   = 4'b0100;
    localparam logic [3:0] FN_XOR  = 4'b0101;
    localparam logic [3:0] FN_NOT  = 4'b0110;
    localparam logic [3:0] FN_ADDS = 4'b1001;
    localparam logic [3:0] FN_SUBS = 4'b1010;
    localparam logic [3:0] FN_ANDS = 4'b1011;
    localparam logic [3:0] FN_ORS  = 4'b1100;
    localparam logic [3:0] FN_XORS = 4'b1101;

    localparam logic [2:0] MV_MOV  = 3'b000;
    localparam logic [2:0] MV_MOVT = 3'b001;
    localparam logic [2:0] MV_CLR  = 3'b010;
    localparam logic [2:0] MV_SET  = 3'b011;
    localparam logic [2:0] MV_LSL  = 3'b100;
    localparam logic [2:0] MV_LSR  = 3'b101;
    localparam logic [2:0] MV_MOVF = 3'b110;
    localparam logic [2:0] MV_SAVF = 3'b111;

    localparam logic [3:0] BR_EQ  = 4'b0000;
    localparam logic [3:0] BR_NE  = 4'b0001;
    localparam logic [3:0] BR_REG = 4'b0010;
    localparam logic [3:0] BR_LO  = 4'b0011;
    localparam logic [3:0] BR_MI  = 4'b0100;
    localparam logic [3:0] BR_PL  = 4'b0101;
    localparam logic [3:0] BR_VS  = 4'b0110;
    localparam logic [3:0] BR_VC  = 4'b0111;
    localparam logic [3:0] BR_HI  = 4'b1000;
    localparam logic [3:0] BR_LS  = 4'b1001;
    localparam logic [3:0] BR_GE  = 4'b1010;
    localparam logic [3:0] BR_LT  = 4'b1011;
    localparam logic [3:0] BR_GT  = 4'b1100;
    localparam logic [3:0] BR_LE  = 4'b1101;

    typedef enum logic [4:0] {
        OP_NONE, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
        OP_MOV, OP_MOVT, OP_CLR, OP_SET, OP_LSL, OP_LSR, OP_MOVF, OP_SAVF,
        OP_LOAD, OP_STORE, OP_BRANCH
    } execOp_e;

endpackage

/* design/execDecode.sv */
`timescale 1ns/1ns

module execDecode (
    input  logic [1:0]      firstLevelDecode,
    input  logic            specialEncoding,
    input  logic [3:0]      secondLevelDecode,
    input  logic [2:0]      aluFunctions,
    input  execPkg::regIdx_t destReg,
    input  execPkg::regIdx_t sourceFirstReg,
    input  execPkg::regIdx_t sourceSecReg,
    output execPkg::execOp_e op,
    output logic            setsFlags,
    output logic            useReg,
    output logic            isLoad,
    output logic            isStore,
    output execPkg::regIdx_t readRegDest,
    output execPkg::regIdx_t readRegFirst,
    output execPkg::regIdx_t readRegSec
);
    import execPkg::*;

    // Same function field for immediate and register forms
    function automatic execOp_e fnToOp(input logic [3:0] fn);
        case (fn)
            FN_ADD, FN_ADDS: return OP_ADD;
            FN_SUB, FN_SUBS: return OP_SUB;
            FN_AND, FN_ANDS: return OP_AND;
            FN_OR,  FN_ORS:  return OP_OR;
            FN_XOR, FN_XORS: return OP_XOR;
            FN_NOT:          return OP_NOT;
            default:         return OP_NONE;  // Multiply and spare codes
        endcase
    endfunction

    always_comb begin
        op           = OP_NONE;
        setsFlags    = 1'b0;
        useReg       = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        readRegDest  = '0;
        readRegFirst = '0;
        readRegSec   = '0;
        case (firstLevelDecode)
            CLASS_IMM: begin
                readRegDest = destReg;
                if (specialEncoding) begin
                    op           = fnToOp(secondLevelDecode);
                    setsFlags    = secondLevelDecode[3] && (op != OP_NONE);
                    readRegFirst = sourceFirstReg;
                end else begin
                    case (aluFunctions)
                        MV_MOV:  op = OP_MOV;
                        MV_MOVT: op = OP_MOVT;
                        MV_CLR:  op = OP_CLR;
                        MV_SET:  op = OP_SET;
                        MV_LSL:  op = OP_LSL;
                        MV_LSR:  op = OP_LSR;
                        MV_MOVF: op = OP_MOVF;
                        MV_SAVF: op = OP_SAVF;
                        default: op = OP_NONE;
                    endcase
                    if (op == OP_LSL || op == OP_LSR) begin
                        readRegFirst = sourceFirstReg;  // Shift source
                    end
                end
            end
            CLASS_REG: begin
                op           = fnToOp(secondLevelDecode);
                setsFlags    = secondLevelDecode[3] && (op != OP_NONE);
                useReg       = 1'b1;
                readRegDest  = destReg;
                readRegFirst = sourceFirstReg;
                readRegSec   = (op == OP_NOT) ? '0 : sourceSecReg;
            end
            CLASS_MEM: begin
                op           = aluFunctions[0] ? OP_STORE : OP_LOAD;
                isStore      = aluFunctions[0];
                isLoad       = !aluFunctions[0];
                readRegDest  = destReg;          // Store data or load target
                readRegFirst = sourceFirstReg;   // Base address
            end
            default: begin
                op           = OP_BRANCH;
                readRegFirst = sourceFirstReg;   // BR base
            end
        endcase
    end

endmodule

/* design/execAlu.sv */
`timescale 1ns/1ns

module execAlu (
    input  execPkg::execOp_e op,
    input  logic            setsFlags,
    input  logic            useReg,
    input  execPkg::imm_t    imm,
    input  execPkg::word_t   readDataDest,
    input  execPkg::word_t   readDataFirst,
    input  execPkg::word_t   readDataSec,
    input  execPkg::word_t   memoryDataIn,
    input  execPkg::flags_t  flags,
    output execPkg::word_t   writeData,
    output logic            writeToReg,
    output execPkg::flags_t  flagsNext
);
    import execPkg::*;

    word_t                 immExt;
    word_t                 operandB;
    logic [WORD_WIDTH:0]   sum;
    logic [WORD_WIDTH:0]   diff;
    logic                  signA;
    logic                  signB;

    assign immExt   = {{(WORD_WIDTH-16){imm[15]}}, imm};
    assign operandB = useReg ? readDataSec : immExt;
    assign sum      = {1'b0, readDataFirst} + {1'b0, operandB};
    assign diff     = {1'b0, readDataFirst} - {1'b0, operandB};  // MSB is the borrow
    assign signA    = readDataFirst[WORD_WIDTH-1];
    assign signB    = operandB[WORD_WIDTH-1];

    always_comb begin
        writeData  = '0;
        writeToReg = 1'b1;
        case (op)
            OP_ADD:  writeData = sum[WORD_WIDTH-1:0];
            OP_SUB:  writeData = diff[WORD_WIDTH-1:0];
            OP_AND:  writeData = readDataFirst & operandB;
            OP_OR:   writeData = readDataFirst | operandB;
            OP_XOR:  writeData = readDataFirst ^ operandB;
            OP_NOT:  writeData = ~readDataFirst;
            OP_MOV:  writeData = {{(WORD_WIDTH-16){1'b0}}, imm};
            OP_MOVT: writeData = {imm, readDataDest[15:0]};  // Keep low half
            OP_CLR:  writeData = '0;
            OP_SET:  writeData = '1;
            OP_LSL:  writeData = readDataFirst << imm;
            OP_LSR:  writeData = readDataFirst >> imm;
            OP_MOVF: writeData = {{(WORD_WIDTH-4){1'b0}}, flags};
            OP_LOAD: writeData = memoryDataIn;          // Load data straight through
            default: writeToReg = 1'b0;                 // SAVF, store, branch, none
        endcase
    end

    always_comb begin
        flagsNext = flags;
        if (op == OP_SAVF) begin
            flagsNext = readDataDest[3:0];
        end else if (setsFlags) begin
            // N and Z for every flag-setting op
            flagsNext[FLAG_N] = writeData[WORD_WIDTH-1];
            flagsNext[FLAG_Z] = (writeData == '0);
            if (op == OP_ADD) begin
                flagsNext[FLAG_C] = sum[WORD_WIDTH];
                flagsNext[FLAG_V] = !(signA ^ signB) && (signA ^ writeData[WORD_WIDTH-1]);
            end else if (op == OP_SUB) begin
                flagsNext[FLAG_C] = !diff[WORD_WIDTH];  // Inverted borrow
                flagsNext[FLAG_V] = (signA ^ signB) && (signA ^ writeData[WORD_WIDTH-1]);
            end
        end
    end

endmodule

/* design/flagRegister.sv */
`timescale 1ns/1ns

module flagRegister (
    input  logic            clk,
    input  logic            rst,
    input  execPkg::flags_t  flagsNext,
    output execPkg::flags_t  flags
);
    import execPkg::*;

    // Reloaded every cycle from the ALU's next value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= flagsNext;
        end
    end

    // Flags feed branches and MOVF, so an X here would spread
    flagsKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(flags));

endmodule

/* design/branchUnit.sv */
`timescale 1ns/1ns

module branchUnit (
    input  logic            enable,
    input  logic [3:0]      branchInstruction,
    input  execPkg::imm_t    imm,
    input  execPkg::word_t   readDataFirst,
    input  execPkg::flags_t  flags,
    output logic            exeOverride,
    output execPkg::target_t exeData
);
    import execPkg::*;

    logic n, z, c, v;
    logic taken;

    assign n = flags[FLAG_N];
    assign z = flags[FLAG_Z];
    assign c = flags[FLAG_C];
    assign v = flags[FLAG_V];

    always_comb begin
        case (branchInstruction)
            BR_EQ:   taken = z;
            BR_NE:   taken = !z;
            BR_REG:  taken = 1'b1;           // Unconditional register branch
            BR_LO:   taken = !c;
            BR_MI:   taken = n;
            BR_PL:   taken = !n;
            BR_VS:   taken = v;
            BR_VC:   taken = !v;
            BR_HI:   taken = !z && c;
            BR_LS:   taken = !(!z && c);
            BR_GE:   taken = (n == v);
            BR_LT:   taken = (n != v);
            BR_GT:   taken = !z && (n == v);
            BR_LE:   taken = !(!z && (n == v));
            default: taken = 1'b0;           // 1110 and 1111 undefined
        endcase
    end

    assign exeOverride = enable && taken;

    // BR is base plus offset, conditionals jump to the immediate
    assign exeData = (branchInstruction == BR_REG) ? readDataFirst[15:0] + imm : imm;

endmodule

/* design/memAccess.sv */
`timescale 1ns/1ns

module memAccess (
    input  logic           clk,
    input  logic           rst,
    input  logic           isLoad,
    input  logic           isStore,
    input  execPkg::imm_t   imm,
    input  execPkg::word_t  readDataFirst,
    input  execPkg::word_t  readDataDest,
    output logic           memoryRead,
    output logic           memoryWrite,
    output execPkg::word_t  memoryAddressOut,
    output execPkg::word_t  memoryDataOut
);
    import execPkg::*;

    word_t effAddr;
    word_t storeAddr;
    word_t storeData;

    assign effAddr = readDataFirst + {{(WORD_WIDTH-16){imm[15]}}, imm};  // Base plus offset

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memoryWrite <= 1'b0;
        end else begin
            memoryWrite <= isStore;  // High for the one cycle after the store
        end
    end

    always_ff @(posedge clk) begin
        if (isStore) begin
            storeAddr <= effAddr;
            storeData <= readDataDest;
        end
    end

    assign memoryRead       = isLoad;
    assign memoryAddressOut = isLoad ? effAddr : storeAddr;  // Load address wins
    assign memoryDataOut    = storeData;

    rdWrExclusive: assert property (@(posedge clk) disable iff (rst)
        !(memoryRead && memoryWrite));

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0]       firstLevelDecode,
    input  logic             specialEncoding,
    input  logic [3:0]       secondLevelDecode,
    input  logic [2:0]       aluFunctions,
    input  logic [3:0]       branchInstruction,
    input  execPkg::imm_t     imm,
    input  execPkg::regIdx_t  destReg,
    input  execPkg::regIdx_t  sourceFirstReg,
    input  execPkg::regIdx_t  sourceSecReg,
    input  execPkg::word_t    readDataDest,
    input  execPkg::word_t    readDataFirst,
    input  execPkg::word_t    readDataSec,
    input  execPkg::word_t    memoryDataIn,
    output execPkg::regIdx_t  readRegDest,
    output execPkg::regIdx_t  readRegFirst,
    output execPkg::regIdx_t  readRegSec,
    output execPkg::word_t    writeData,
    output logic             writeToReg,
    output logic             exeOverride,
    output execPkg::target_t  exeData,
    output execPkg::flags_t   flagsOut,
    output execPkg::word_t    memoryDataOut,
    output execPkg::word_t    memoryAddressOut,
    output logic             memoryWrite,
    output logic             memoryRead
);
    import execPkg::*;

    execOp_e op;
    logic    setsFlags;
    logic    useReg;
    logic    isLoad;
    logic    isStore;
    flags_t  flagsNext;

    execDecode decoder (
        .firstLevelDecode(firstLevelDecode), .specialEncoding(specialEncoding),
        .secondLevelDecode(secondLevelDecode), .aluFunctions(aluFunctions),
        .destReg(destReg), .sourceFirstReg(sourceFirstReg), .sourceSecReg(sourceSecReg),
        .op(op), .setsFlags(setsFlags), .useReg(useReg), .isLoad(isLoad), .isStore(isStore),
        .readRegDest(readRegDest), .readRegFirst(readRegFirst), .readRegSec(readRegSec)
    );

    execAlu alu (
        .op(op), .setsFlags(setsFlags), .useReg(useReg), .imm(imm),
        .readDataDest(readDataDest), .readDataFirst(readDataFirst),
        .readDataSec(readDataSec), .memoryDataIn(memoryDataIn), .flags(flagsOut),
        .writeData(writeData), .writeToReg(writeToReg), .flagsNext(flagsNext)
    );

    // Flag register output doubles as the flagsOut port
    flagRegister flagReg (
        .clk(clk), .rst(rst), .flagsNext(flagsNext), .flags(flagsOut)
    );

    branchUnit branch (
        .enable(op == OP_BRANCH), .branchInstruction(branchInstruction), .imm(imm),
        .readDataFirst(readDataFirst), .flags(flagsOut),
        .exeOverride(exeOverride), .exeData(exeData)
    );

    memAccess mem (
        .clk(clk), .rst(rst), .isLoad(isLoad), .isStore(isStore), .imm(imm),
        .readDataFirst(readDataFirst), .readDataDest(readDataDest),
        .memoryRead(memoryRead), .memoryWrite(memoryWrite),
        .memoryAddressOut(memoryAddressOut), .memoryDataOut(memoryDataOut)
    );

endmodule

/* test/executeStageTb.sv */
`timescale 1ns/1ns

module executeStageTb;
    import execPkg::*;

    localparam int N_ALU = 200;
    localparam int N_FLAG = 100;
    localparam int N_MOVE = 48 + 32;        // Moves, then 16 SAVF/MOVF pairs
    localparam int N_BRANCH = 16 * 17;      // SAVF plus 16 codes per flag value
    localparam int N_MEM = 20 * 3;          // Store, idle, load
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT = 2 * (N_ALU + N_FLAG + N_MOVE + N_BRANCH + N_MEM) + RESET_CYCLES;

    logic clk;
    logic rst;
    logic [1:0] firstLevelDecode;
    logic specialEncoding;
    logic [3:0] secondLevelDecode;
    logic [2:0] aluFunctions;
    logic [3:0] branchInstruction;
    imm_t imm;
    regIdx_t destReg, sourceFirstReg, sourceSecReg, readRegDest, readRegFirst, readRegSec;
    word_t readDataDest, readDataFirst, readDataSec, memoryDataIn;
    word_t writeData, memoryDataOut, memoryAddressOut;
    logic writeToReg, exeOverride, memoryWrite, memoryRead;
    target_t exeData;
    flags_t flagsOut;

    int seed = 86581;
    int errorCount = 0;
    int vectorCount = 0;
    int cycleCount = 0;
    logic checking = 1'b0;
    flags_t modelFlags = '0;
    logic storePending = 1'b0;
    word_t pendAddr, pendData;
    word_t expData, immExt;
    logic expWrite, expOvr, expLoad, nextStore;
    logic [2:0] regsRead;
    flags_t expFlags;
    target_t expTarget;

    executeStage UUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic word_t rnd();
        return $random(seed);
    endfunction

    function automatic word_t cornerValue(input logic [1:0] sel);
        case (sel)
            2'd0: return 32'h7FFFFFFF;
            2'd1: return 32'h80000000;
            2'd2: return 32'hFFFFFFFF;
            default: return 32'h00000000;
        endcase
    endfunction

    // Expected stage results from the instruction rules
    function automatic void refModel(
        input logic [1:0] cls, input logic spec, input logic [3:0] fn, input logic [2:0] mv,
        input logic [3:0] br, input imm_t immV, input word_t rd, input word_t rf,
        input word_t rs, input word_t mem, input flags_t fl,
        output word_t wd, output logic wr, output flags_t nf, output logic ovr,
        output target_t tgt);
        word_t immS;
        word_t b;
        logic carry;
        immS = {{16{immV[15]}}, immV};
        b = (cls == CLASS_REG) ? rs : immS;
        wd = '0;
        wr = 1'b0;
        nf = fl;
        ovr = 1'b0;
        tgt = immV;
        carry = 1'b0;
        if (cls == CLASS_REG || (cls == CLASS_IMM && spec)) begin
            wr = 1'b1;
            case (fn)
                FN_ADD, FN_ADDS: {carry, wd} = {1'b0, rf} + {1'b0, b};
                FN_SUB, FN_SUBS: wd = rf - b;
                FN_AND, FN_ANDS: wd = rf & b;
                FN_OR, FN_ORS:   wd = rf | b;
                FN_XOR, FN_XORS: wd = rf ^ b;
                FN_NOT:          wd = ~rf;
                default:         wr = 1'b0;   // Multiply and spare codes do nothing
            endcase
            if (fn[3] && wr) begin
                nf[FLAG_N] = wd[31];
                nf[FLAG_Z] = (wd == 32'h0);
            end
            if (fn == FN_ADDS) begin
                nf[FLAG_C] = carry;
                nf[FLAG_V] = (rf[31] == b[31]) && (wd[31] != rf[31]);
            end else if (fn == FN_SUBS) begin
                nf[FLAG_C] = (rf >= b);      // Set when no borrow
                nf[FLAG_V] = (rf[31] != b[31]) && (wd[31] != rf[31]);
            end
        end else if (cls == CLASS_IMM) begin
            wr = (mv != MV_SAVF);
            case (mv)
                MV_MOV:  wd = {16'h0000, immV};
                MV_MOVT: wd = {immV, rd[15:0]};
                MV_CLR:  wd = '0;
                MV_SET:  wd = '1;
                MV_LSL:  wd = rf << immV;
                MV_LSR:  wd = rf >> immV;
                MV_MOVF: wd = {28'h0, fl};
                default: nf = rd[3:0];
            endcase
        end else if (cls == CLASS_MEM) begin
            wr = !mv[0];
            wd = mem;
        end else begin
            case (br)
                BR_EQ:   ovr = fl[FLAG_Z];
                BR_NE:   ovr = !fl[FLAG_Z];
                BR_REG:  ovr = 1'b1;
                BR_LO:   ovr = !fl[FLAG_C];
                BR_MI:   ovr = fl[FLAG_N];
                BR_PL:   ovr = !fl[FLAG_N];
                BR_VS:   ovr = fl[FLAG_V];
                BR_VC:   ovr = !fl[FLAG_V];
                BR_HI:   ovr = fl[FLAG_C] && !fl[FLAG_Z];
                BR_LS:   ovr = !fl[FLAG_C] || fl[FLAG_Z];
                BR_GE:   ovr = (fl[FLAG_N] == fl[FLAG_V]);
                BR_LT:   ovr = (fl[FLAG_N] != fl[FLAG_V]);
                BR_GT:   ovr = !fl[FLAG_Z] && (fl[FLAG_N] == fl[FLAG_V]);
                BR_LE:   ovr = fl[FLAG_Z] || (fl[FLAG_N] != fl[FLAG_V]);
                default: ovr = 1'b0;
            endcase
            if (br == BR_REG) tgt = rf[15:0] + immV;
        end
    endfunction

    // Register operands each instruction reads, as {dest, first, second}
    function automatic logic [2:0] operandsRead(
        input logic [1:0] cls, input logic spec, input logic [3:0] fn,
        input logic [2:0] mv, input logic [3:0] br);
        logic aluFn;
        aluFn = fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOT,
                           FN_ADDS, FN_SUBS, FN_ANDS, FN_ORS, FN_XORS};
        case (cls)
            CLASS_IMM: begin
                if (spec) begin
                    return {1'b0, aluFn, 1'b0};
                end
                return {mv inside {MV_MOVT, MV_SAVF}, mv inside {MV_LSL, MV_LSR}, 1'b0};
            end
            CLASS_REG: return {1'b0, aluFn, aluFn && (fn != FN_NOT)};
            CLASS_MEM: return {mv[0], 1'b1, 1'b0};    // Store data, base
            default:   return {1'b0, br == BR_REG, 1'b0};
        endcase
    endfunction

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkFlags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkTarget(input string name, input target_t exp, input target_t act);
        if (act !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkIndex(input string name, input regIdx_t exp, input regIdx_t act);
        if (act !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Compare just before each rising edge, advance the model at the edge
    always begin
        @(negedge clk);
        #3;
        if (checking) begin
            refModel(firstLevelDecode, specialEncoding, secondLevelDecode, aluFunctions,
                     branchInstruction, imm, readDataDest, readDataFirst, readDataSec,
                     memoryDataIn, modelFlags, expData, expWrite, expFlags, expOvr, expTarget);
            regsRead = operandsRead(firstLevelDecode, specialEncoding, secondLevelDecode,
                                    aluFunctions, branchInstruction);
            immExt = {{16{imm[15]}}, imm};
            expLoad = (firstLevelDecode == CLASS_MEM) && !aluFunctions[0];
            nextStore = (firstLevelDecode == CLASS_MEM) && aluFunctions[0];
            if (regsRead[2]) checkIndex("readRegDest", destReg, readRegDest);
            if (regsRead[1]) checkIndex("readRegFirst", sourceFirstReg, readRegFirst);
            if (regsRead[0]) checkIndex("readRegSec", sourceSecReg, readRegSec);
            checkBit("writeToReg", expWrite, writeToReg);
            if (expWrite) checkWord("writeData", expData, writeData);
            checkFlags("flagsOut", modelFlags, flagsOut);
            checkBit("exeOverride", expOvr, exeOverride);
            if (expOvr) checkTarget("exeData", expTarget, exeData);
            checkBit("memoryRead", expLoad, memoryRead);
            checkBit("memoryWrite", storePending, memoryWrite);
            if (expLoad) begin
                checkWord("memoryAddressOut", readDataFirst + immExt, memoryAddressOut);
            end else if (storePending) begin
                checkWord("memoryAddressOut", pendAddr, memoryAddressOut);
                checkWord("memoryDataOut", pendData, memoryDataOut);
            end
            vectorCount++;
            @(posedge clk);
            modelFlags = expFlags;
            storePending = nextStore;
            pendAddr = readDataFirst + immExt;
            pendData = readDataDest;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic setOp(input logic [1:0] cls, input logic spec, input logic [3:0] fn,
                         input logic [2:0] mv, input logic [3:0] br);
        firstLevelDecode = cls;
        specialEncoding = spec;
        secondLevelDecode = fn;
        aluFunctions = mv;
        branchInstruction = br;
    endtask

    task automatic loadRandomData();
        word_t r;
        r = rnd();
        imm = r[15:0];
        destReg = r[19:16];
        sourceFirstReg = r[23:20];
        sourceSecReg = r[27:24];
        readDataDest = rnd();
        readDataFirst = rnd();
        readDataSec = rnd();
        memoryDataIn = rnd();
    endtask

    task automatic idle();
        setOp(CLASS_IMM, 1'b1, 4'b0000, 3'b000, 4'b0000);  // Decodes to no operation
    endtask

    task automatic finishTest(input string name, input int startErrors);
        @(posedge clk);
        $display("%s finished with %0d errors", name, errorCount - startErrors);
    endtask

    task automatic aluTest(input logic withFlags, input int count);
        word_t r;
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            loadRandomData();
            r = rnd();
            if (withFlags) begin
                setOp(r[0] ? CLASS_REG : CLASS_IMM, 1'b1, {1'b1, 3'(1 + r[15:8] % 5)},
                      3'b0, 4'b0);
                if (r[2]) readDataFirst = cornerValue(r[5:4]);
                if (r[3]) readDataSec = cornerValue(r[7:6]);
            end else begin
                setOp(r[0] ? CLASS_REG : CLASS_IMM, 1'b1, 4'(1 + r[15:8] % 6), 3'b0, 4'b0);
            end
        end
        finishTest(withFlags ? "Flag-setting ops" : "ALU ops", startErrors);
    endtask

    task automatic moveTest();
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < 48; i++) begin
            @(negedge clk);
            loadRandomData();
            setOp(CLASS_IMM, 1'b0, 4'b0, 3'(i % 6), 4'b0);
            if (i % 6 >= 4) imm = {10'h0, imm[5:0]};  // Shift counts up to 63
        end
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            loadRandomData();
            readDataDest[3:0] = 4'(k);
            setOp(CLASS_IMM, 1'b0, 4'b0, MV_SAVF, 4'b0);
            @(negedge clk);
            loadRandomData();
            setOp(CLASS_IMM, 1'b0, 4'b0, MV_MOVF, 4'b0);
        end
        finishTest("Move group", startErrors);
    endtask

    task automatic branchTest();
        int startErrors;
        startErrors = errorCount;
        for (int f = 0; f < 16; f++) begin
            @(negedge clk);
            loadRandomData();
            readDataDest = 32'(f);
            setOp(CLASS_IMM, 1'b0, 4'b0, MV_SAVF, 4'b0);
            for (int code = 0; code < 16; code++) begin
                @(negedge clk);
                loadRandomData();
                setOp(CLASS_BRANCH, 1'b0, 4'b0, 3'b0, 4'(code));
            end
        end
        finishTest("Branches", startErrors);
    endtask

    task automatic memoryTest();
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            loadRandomData();
            setOp(CLASS_MEM, 1'b0, 4'b0, 3'b001, 4'b0);   // Store
            @(negedge clk);
            loadRandomData();
            idle();                                        // Keeps loads off the write cycle
            @(negedge clk);
            loadRandomData();
            setOp(CLASS_MEM, 1'b0, 4'b0, 3'b000, 4'b0);   // Load
        end
        finishTest("Memory access", startErrors);
    endtask

    initial begin
        rst = 1'b1;
        idle();
        loadRandomData();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checking = 1'b1;
        aluTest(1'b0, N_ALU);
        aluTest(1'b1, N_FLAG);
        moveTest();
        branchTest();
        memoryTest();
        @(negedge clk);
        idle();
        @(posedge clk);
        $display("Summary: %0d vectors checked, %0d errors", vectorCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* executeStage.f */
design/execPkg.sv
design/execDecode.sv
design/execAlu.sv
design/flagRegister.sv
design/branchUnit.sv
design/memAccess.sv
design/executeStage.sv
test/executeStageTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module executeStageTb -f executeStage.f -o simv
out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
